//--- build.f
src/alignPkg.sv
src/max7Tree.sv
src/neighborDelay.sv
src/cellUpdate.sv
src/alignCell.sv
bench/tbClock.sv
bench/alignChecker.sv
bench/alignCellTb.sv

//--- Bender.yml
package:
  name: align_cell

sources:
  - src/alignPkg.sv
  - src/max7Tree.sv
  - src/neighborDelay.sv
  - src/cellUpdate.sv
  - src/alignCell.sv
  - target: simulation
    files:
      - bench/tbClock.sv
      - bench/alignChecker.sv
      - bench/alignCellTb.sv

//--- bench/alignCellTb.sv
`timescale 1ns/1ps

module alignCellTb import alignPkg::*; ();

  localparam int PERIOD       = 20;
  localparam int RESET_CYCLES = 3;
  localparam int MATCH        = 1;
  localparam int MISMATCH     = -1;
  localparam int GAP_OPEN     = 2;
  localparam int GAP_EXTEND   = 1;

  localparam int START_ROUNDS = 2;
  localparam int IDLE_LEN     = 4;
  localparam int BURST_LEN    = 10;
  localparam int RANDOM_LEN   = 2000;
  localparam int BASE_LEN     = 4;
  localparam int EDGE_LEN     = 8;
  localparam int DRAIN_LEN    = 3;
  localparam int TOTAL_CYCLES = RESET_CYCLES + START_ROUNDS * (IDLE_LEN + BURST_LEN)
                                + RANDOM_LEN + 5 * BASE_LEN + 2 * EDGE_LEN + DRAIN_LEN;

  logic      clk;
  logic      rst;
  cellIn_t   cellIn;
  scoreVec_t state;
  base_t     baseA;
  logic      en;
  int        errors;
  int        checks;
  int        starts;
  int        seed;

  tbClock #(.PERIOD(PERIOD), .RESET_CYCLES(RESET_CYCLES)) tbClock_inst (
    .clk_o (clk),
    .rst_o (rst)
  );

  alignCell #(
    .MATCH      (MATCH),
    .MISMATCH   (MISMATCH),
    .GAP_OPEN   (GAP_OPEN),
    .GAP_EXTEND (GAP_EXTEND)
  ) alignCell_inst (
    .clk      (clk),
    .rst      (rst),
    .cellIn_i (cellIn),
    .state_o  (state),
    .baseA_o  (baseA),
    .en_o     (en)
  );

  alignChecker #(
    .MATCH      (MATCH),
    .MISMATCH   (MISMATCH),
    .GAP_OPEN   (GAP_OPEN),
    .GAP_EXTEND (GAP_EXTEND)
  ) alignChecker_inst (
    .clk_i    (clk),
    .rst_i    (rst),
    .cellIn_i (cellIn),
    .state_i  (state),
    .baseA_i  (baseA),
    .en_i     (en),
    .errors_o (errors),
    .checks_o (checks),
    .starts_o (starts)
  );

  // scores in -200..200
  function automatic score_t randScore();
    return score_t'($random(seed) % 201);
  endfunction

  function automatic scoreVec_t randVec();
    scoreVec_t v;
    for (int f = 0; f < 7; f++) v[f * SCORE_W +: SCORE_W] = randScore();
    return v;
  endfunction

  // just above the most negative score, so costs wrap
  function automatic scoreVec_t lowVec();
    scoreVec_t v;
    for (int f = 0; f < 7; f++) begin
      v[f * SCORE_W +: SCORE_W] = score_t'(-1024 + ($random(seed) & 7));
    end
    return v;
  endfunction

  task automatic driveCycle(input cellIn_t v);
    @(posedge clk);
    #1;
    cellIn = v;
  endtask

  function automatic cellIn_t randInput(logic enVal);
    cellIn_t v;
    v.n1 = randVec();
    v.n2 = randVec();
    v.n3 = randVec();
    v.a  = base_t'($random(seed));
    v.b  = base_t'($random(seed));
    v.c  = base_t'($random(seed));
    v.en = enVal;
    return v;
  endfunction

  task automatic randomCycles(input int n, input logic enVal);
    repeat (n) driveCycle(randInput(enVal));
  endtask

  task automatic baseCycles(input base_t a, input base_t b, input base_t c, input int n);
    cellIn_t v;
    repeat (n) begin
      v   = randInput(1'b1);
      v.a = a;
      v.b = b;
      v.c = c;
      driveCycle(v);
    end
  endtask

  // flat vectors force ties in every max tree
  task automatic edgeCycles(input int n, input logic nearLimit);
    cellIn_t v;
    score_t  s;
    repeat (n) begin
      v = randInput(1'b1);
      s = randScore();
      v.n1 = nearLimit ? lowVec() : scoreVec_t'({7{s}});
      v.n2 = nearLimit ? lowVec() : scoreVec_t'({7{s}});
      v.n3 = nearLimit ? lowVec() : scoreVec_t'({7{s}});
      driveCycle(v);
    end
  endtask

  initial begin
    cellIn = '0;
    seed   = 32'hee49_9c9e;
    wait (rst === 1'b1);
    wait (rst === 1'b0);
    // enable rising after idle columns
    repeat (START_ROUNDS) begin
      randomCycles(IDLE_LEN, 1'b0);
      randomCycles(BURST_LEN, 1'b1);
    end
    randomCycles(RANDOM_LEN, 1'b1);
    baseCycles(2'd2, 2'd2, 2'd2, BASE_LEN);
    baseCycles(2'd0, 2'd1, 2'd2, BASE_LEN);
    baseCycles(2'd1, 2'd1, 2'd3, BASE_LEN);
    baseCycles(2'd0, 2'd2, 2'd2, BASE_LEN);
    baseCycles(2'd3, 2'd1, 2'd3, BASE_LEN);
    edgeCycles(EDGE_LEN, 1'b0);
    edgeCycles(EDGE_LEN, 1'b1);
    randomCycles(DRAIN_LEN, 1'b1);
    repeat (2) @(negedge clk);
    if (starts == 0) $display("no enabled start column was exercised");
    $display("closing: %0d errors in %0d checks, %0d start columns", errors, checks, starts);
    if (errors == 0 && starts > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #((TOTAL_CYCLES + 20) * PERIOD);
    $display("timeout: the run did not reach its end in time");
    $display("Regression failed");
    $finish;
  end

endmodule

//--- bench/alignChecker.sv
`timescale 1ns/1ps

module alignChecker import alignPkg::*; #(
  parameter int MATCH      = 1,
  parameter int MISMATCH   = -1,
  parameter int GAP_OPEN   = 2,
  parameter int GAP_EXTEND = 1
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  cellIn_t   cellIn_i,
  input  scoreVec_t state_i,
  input  base_t     baseA_i,
  input  logic      en_i,
  output int        errors_o,
  output int        checks_o,
  output int        starts_o
);

  // model copies of the delay lines and the cell state
  scoreVec_t mState = '0;
  scoreVec_t n1D1   = '0;
  scoreVec_t n1D2   = '0;
  scoreVec_t n2D1   = '0;
  scoreVec_t n3D1   = '0;
  base_t     baseA  = '0;
  base_t     baseB  = '0;
  base_t     baseC  = '0;
  logic      enReg  = 1'b0;
  logic      resetSeen  = 1'b0;
  int        errCount   = 0;
  int        checkCount = 0;
  int        startCount = 0;

  assign errors_o = errCount;
  assign checks_o = checkCount;
  assign starts_o = startCount;

  // field 0 is m, field 6 is ixz
  function automatic score_t fieldOf(scoreVec_t v, int f);
    return v[(6 - f) * SCORE_W +: SCORE_W];
  endfunction

  function automatic string fieldName(int f);
    case (f)
      0: return "state_o.m";
      1: return "state_o.ix";
      2: return "state_o.iy";
      3: return "state_o.iz";
      4: return "state_o.ixy";
      5: return "state_o.iyz";
      default: return "state_o.ixz";
    endcase
  endfunction

  // gap cost of moving from source field f into target state t
  function automatic int gapCost(int t, int f);
    case (t)
      1: return (f == 0 || f == 5) ? 2 * GAP_OPEN : (f == 1) ? 2 * GAP_EXTEND
                : GAP_OPEN + GAP_EXTEND;
      2: return (f == 0 || f == 6) ? 2 * GAP_OPEN : (f == 2) ? 2 * GAP_EXTEND
                : GAP_OPEN + GAP_EXTEND;
      3: return (f == 0 || f == 4) ? 2 * GAP_OPEN : (f == 3) ? 2 * GAP_EXTEND
                : GAP_OPEN + GAP_EXTEND;
      4: return (f == 1 || f == 2 || f == 4) ? GAP_EXTEND : GAP_OPEN;
      5: return (f == 2 || f == 3 || f == 5) ? GAP_EXTEND : GAP_OPEN;
      6: return (f == 1 || f == 3 || f == 6) ? GAP_EXTEND : GAP_OPEN;
      default: return 0;
    endcase
  endfunction

  function automatic int pairScore(base_t x, base_t y);
    return (x == y) ? MATCH : MISMATCH;
  endfunction

  // where each target state takes its seven sources from
  function automatic scoreVec_t sourceOf(int t);
    case (t)
      0: return n1D2;
      1: return mState;
      2: return cellIn_i.n2;
      3: return cellIn_i.n3;
      4: return n2D1;
      5: return n1D1;
      default: return n3D1;
    endcase
  endfunction

  task automatic stepModel();
    scoreVec_t nxt;
    scoreVec_t src;
    score_t    cand;
    score_t    best;
    int        bonus;
    int        pAB;
    int        pBC;
    int        pAC;
    logic      start;
    start = cellIn_i.en && !enReg;
    pAB = pairScore(baseA, baseB);
    pBC = pairScore(baseB, baseC);
    pAC = pairScore(baseA, baseC);
    for (int t = 0; t < 7; t++) begin
      src = sourceOf(t);
      // first enabled column starts from zero for M, Ix, Ixy, Ixz
      if (start && (t == 0 || t == 1 || t == 4 || t == 6)) src = '0;
      case (t)
        0: bonus = pAB + pBC + pAC;
        4: bonus = pAB;
        5: bonus = pBC;
        6: bonus = pAC;
        default: bonus = 0;
      endcase
      best = '0;
      for (int f = 0; f < 7; f++) begin
        cand = score_t'(fieldOf(src, f) - gapCost(t, f) + bonus);
        if (f == 0 || cand > best) best = cand;
      end
      nxt[(6 - t) * SCORE_W +: SCORE_W] = best;
    end
    if (start) startCount++;
    mState = nxt;
    n1D2   = n1D1;
    n1D1   = cellIn_i.n1;
    n2D1   = cellIn_i.n2;
    n3D1   = cellIn_i.n3;
    baseA  = cellIn_i.a;
    baseB  = cellIn_i.b;
    baseC  = cellIn_i.c;
    enReg  = cellIn_i.en;
  endtask

  task automatic checkValue(string name, logic [SCORE_W-1:0] dut, logic [SCORE_W-1:0] exp);
    checkCount++;
    if (dut !== exp) begin
      errCount++;
      $display("mismatch %s at %0t: dut %h, model %h", name, $time, dut, exp);
    end
  endtask

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      mState    = '0;
      n1D1      = '0;
      n1D2      = '0;
      n2D1      = '0;
      n3D1      = '0;
      baseA     = '0;
      baseB     = '0;
      baseC     = '0;
      enReg     = 1'b0;
      resetSeen = 1'b1;
    end else begin
      stepModel();
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (resetSeen) begin
      for (int f = 0; f < 7; f++) begin
        checkValue(fieldName(f), fieldOf(state_i, f), fieldOf(mState, f));
      end
      checkValue("baseA_o", baseA_i, baseA);
      checkValue("en_o", en_i, enReg);
    end
  end

endmodule

//--- bench/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset rises just after time zero and drops after a few edges
  initial begin
    rst_o = 1'b0;
    #2;
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

//--- src/alignCell.sv
`timescale 1ns/1ps

module alignCell import alignPkg::*; #(
  parameter int MATCH      = 1,
  parameter int MISMATCH   = -1,
  parameter int GAP_OPEN   = 2,
  parameter int GAP_EXTEND = 1
) (
  input  logic      clk,
  input  logic      rst,
  input  cellIn_t   cellIn_i,
  output scoreVec_t state_o,
  output base_t     baseA_o,
  output logic      en_o
);

  scoreVec_t n1D1;
  scoreVec_t n1D2;
  scoreVec_t n2Live;
  scoreVec_t n2D1;
  scoreVec_t n3Live;
  scoreVec_t n3D1;
  base_t     baseA;
  base_t     baseB;
  base_t     baseC;
  logic      enReg;
  logic      start;

  // input side, delay lines and stored bases
  neighborDelay neighborDelay_inst (
    .clk      (clk),
    .rst      (rst),
    .cellIn_i (cellIn_i),
    .n1D1_o   (n1D1),
    .n1D2_o   (n1D2),
    .n2Live_o (n2Live),
    .n2D1_o   (n2D1),
    .n3Live_o (n3Live),
    .n3D1_o   (n3D1),
    .a_o      (baseA),
    .b_o      (baseB),
    .c_o      (baseC),
    .en_o     (enReg),
    .start_o  (start)
  );

  // scoring, max reduction and state register
  cellUpdate #(
    .MATCH      (MATCH),
    .MISMATCH   (MISMATCH),
    .GAP_OPEN   (GAP_OPEN),
    .GAP_EXTEND (GAP_EXTEND)
  ) cellUpdate_inst (
    .clk      (clk),
    .rst      (rst),
    .n1D1_i   (n1D1),
    .n1D2_i   (n1D2),
    .n2Live_i (n2Live),
    .n2D1_i   (n2D1),
    .n3Live_i (n3Live),
    .n3D1_i   (n3D1),
    .a_i      (baseA),
    .b_i      (baseB),
    .c_i      (baseC),
    .en_i     (enReg),
    .start_i  (start),
    .state_o  (state_o),
    .baseA_o  (baseA_o),
    .en_o     (en_o)
  );

endmodule

//--- src/cellUpdate.sv
`timescale 1ns/1ps

module cellUpdate import alignPkg::*; #(
  parameter int MATCH      = 1,
  parameter int MISMATCH   = -1,
  parameter int GAP_OPEN   = 2,
  parameter int GAP_EXTEND = 1
) (
  input  logic      clk,
  input  logic      rst,
  input  scoreVec_t n1D1_i,
  input  scoreVec_t n1D2_i,
  input  scoreVec_t n2Live_i,
  input  scoreVec_t n2D1_i,
  input  scoreVec_t n3Live_i,
  input  scoreVec_t n3D1_i,
  input  base_t     a_i,
  input  base_t     b_i,
  input  base_t     c_i,
  input  logic      en_i,
  input  logic      start_i,
  output scoreVec_t state_o,
  output base_t     baseA_o,
  output logic      en_o
);

  localparam score_t GO   = score_t'(GAP_OPEN);
  localparam score_t GE   = score_t'(GAP_EXTEND);
  localparam score_t GO2  = score_t'(2 * GAP_OPEN);
  localparam score_t GE2  = score_t'(2 * GAP_EXTEND);
  localparam score_t GOGE = score_t'(GAP_OPEN + GAP_EXTEND);

  // per-field gap cost for each target state
  localparam scoreVec_t NO_COST  = '0;
  localparam scoreVec_t IX_COST  = '{m: GO2, ix: GE2, iy: GOGE, iz: GOGE,
                                     ixy: GOGE, iyz: GO2, ixz: GOGE};
  localparam scoreVec_t IY_COST  = '{m: GO2, ix: GOGE, iy: GE2, iz: GOGE,
                                     ixy: GOGE, iyz: GOGE, ixz: GO2};
  localparam scoreVec_t IZ_COST  = '{m: GO2, ix: GOGE, iy: GOGE, iz: GE2,
                                     ixy: GO2, iyz: GOGE, ixz: GOGE};
  localparam scoreVec_t IXY_COST = '{m: GO, ix: GE, iy: GE, iz: GO,
                                     ixy: GE, iyz: GO, ixz: GO};
  localparam scoreVec_t IYZ_COST = '{m: GO, ix: GO, iy: GE, iz: GE,
                                     ixy: GO, iyz: GE, ixz: GO};
  localparam scoreVec_t IXZ_COST = '{m: GO, ix: GE, iy: GO, iz: GE,
                                     ixy: GO, iyz: GO, ixz: GE};

  score_t    pairAB;
  score_t    pairBC;
  score_t    pairAC;
  score_t    triple;
  scoreVec_t srcM;
  scoreVec_t srcIx;
  scoreVec_t srcIxy;
  scoreVec_t srcIxz;
  scoreVec_t cand [7];
  score_t    best [7];
  scoreVec_t nextState;

  // source minus cost plus substitution, wrapping at SCORE_W
  function automatic scoreVec_t scoreCand(scoreVec_t src, scoreVec_t cost, score_t bonus);
    scoreVec_t res;
    res.m   = src.m - cost.m + bonus;
    res.ix  = src.ix - cost.ix + bonus;
    res.iy  = src.iy - cost.iy + bonus;
    res.iz  = src.iz - cost.iz + bonus;
    res.ixy = src.ixy - cost.ixy + bonus;
    res.iyz = src.iyz - cost.iyz + bonus;
    res.ixz = src.ixz - cost.ixz + bonus;
    return res;
  endfunction

  // pairwise substitution scores on the stored bases
  assign pairAB = (a_i == b_i) ? score_t'(MATCH) : score_t'(MISMATCH);
  assign pairBC = (b_i == c_i) ? score_t'(MATCH) : score_t'(MISMATCH);
  assign pairAC = (a_i == c_i) ? score_t'(MATCH) : score_t'(MISMATCH);
  assign triple = pairAB + pairBC + pairAC;

  // zero boundary at the start of a cell's column
  assign srcM   = start_i ? scoreVec_t'('0) : n1D2_i;
  assign srcIx  = start_i ? scoreVec_t'('0) : state_o;
  assign srcIxy = start_i ? scoreVec_t'('0) : n2D1_i;
  assign srcIxz = start_i ? scoreVec_t'('0) : n3D1_i;

  always_comb begin
    cand[0] = scoreCand(srcM, NO_COST, triple);
    cand[1] = scoreCand(srcIx, IX_COST, '0);
    cand[2] = scoreCand(n2Live_i, IY_COST, '0);
    cand[3] = scoreCand(n3Live_i, IZ_COST, '0);
    cand[4] = scoreCand(srcIxy, IXY_COST, pairAB);
    cand[5] = scoreCand(n1D1_i, IYZ_COST, pairBC);
    cand[6] = scoreCand(srcIxz, IXZ_COST, pairAC);
  end

  for (genvar i = 0; i < 7; i++) begin : gMax
    max7Tree max7Tree_inst (
      .cand_i (cand[i]),
      .max_o  (best[i])
    );
  end

  assign nextState = '{m: best[0], ix: best[1], iy: best[2], iz: best[3],
                       ixy: best[4], iyz: best[5], ixz: best[6]};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_o <= '0;
    end else begin
      state_o <= nextState;
    end
  end

  // bases and enable already sit one stage after the cell input
  assign baseA_o = a_i;
  assign en_o    = en_i;

  // the stored M can never lose against its diagonal candidate
  mNotBelowDiag: assert property (
    @(posedge clk) disable iff (rst)
    1'b1 |=> state_o.m >= $past(cand[0].m)
  );

  // state stays known once out of reset
  stateKnown: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(state_o)
  );

endmodule

//--- src/neighborDelay.sv
`timescale 1ns/1ps

module neighborDelay import alignPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  cellIn_t   cellIn_i,
  output scoreVec_t n1D1_o,
  output scoreVec_t n1D2_o,
  output scoreVec_t n2Live_o,
  output scoreVec_t n2D1_o,
  output scoreVec_t n3Live_o,
  output scoreVec_t n3D1_o,
  output base_t     a_o,
  output base_t     b_o,
  output base_t     c_o,
  output logic      en_o,
  output logic      start_o
);

  // neighbour 1 runs two stages deep, neighbours 2 and 3 one stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      n1D1_o <= '0;
      n1D2_o <= '0;
      n2D1_o <= '0;
      n3D1_o <= '0;
    end else begin
      n1D1_o <= cellIn_i.n1;
      n1D2_o <= n1D1_o;
      n2D1_o <= cellIn_i.n2;
      n3D1_o <= cellIn_i.n3;
    end
  end

  // bases and enable stored for this cell and forwarded downstream
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      a_o  <= '0;
      b_o  <= '0;
      c_o  <= '0;
      en_o <= 1'b0;
    end else begin
      a_o  <= cellIn_i.a;
      b_o  <= cellIn_i.b;
      c_o  <= cellIn_i.c;
      en_o <= cellIn_i.en;
    end
  end

  // live vectors feed the Iy and Iz candidates directly
  assign n2Live_o = cellIn_i.n2;
  assign n3Live_o = cellIn_i.n3;

  // rising edge of the incoming enable marks the first column
  assign start_o = cellIn_i.en & ~en_o;

  // start strobe only means something on a known enable
  enKnown: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(cellIn_i.en)
  );

endmodule

//--- src/max7Tree.sv
`timescale 1ns/1ps

module max7Tree import alignPkg::*; (
  input  scoreVec_t cand_i,
  output score_t    max_o
);

  score_t lvl1A;
  score_t lvl1B;
  score_t lvl1C;
  score_t lvl2A;
  score_t lvl2B;

  function automatic score_t max2(score_t x, score_t y);
    return (x > y) ? x : y;
  endfunction

  // first level, three signed pairs
  assign lvl1A = max2(cand_i.m, cand_i.ix);
  assign lvl1B = max2(cand_i.iy, cand_i.iz);
  assign lvl1C = max2(cand_i.ixy, cand_i.iyz);

  // odd one out joins at the second level
  assign lvl2A = max2(lvl1A, lvl1B);
  assign lvl2B = max2(lvl1C, cand_i.ixz);

  assign max_o = max2(lvl2A, lvl2B);

endmodule

//--- src/alignPkg.sv
package alignPkg;

  // signed score width shared by every datapath word
  localparam int SCORE_W = 11;

  typedef logic signed [SCORE_W-1:0] score_t;

  // nucleotide code, A C G T in two bits
  typedef logic [1:0] base_t;

  // seven affine states of one cell
  typedef struct packed {
    score_t m;
    score_t ix;
    score_t iy;
    score_t iz;
    score_t ixy;
    score_t iyz;
    score_t ixz;
  } scoreVec_t;

  // everything that enters a cell on one clock
  typedef struct packed {
    scoreVec_t n1;
    scoreVec_t n2;
    scoreVec_t n3;
    base_t     a;
    base_t     b;
    base_t     c;
    logic      en;
  } cellIn_t;

endpackage
